/* rtl/sfr_pkg.sv */
/* register map for the tick timer sfr block
   offsets, action key, reset values, read masks and the access kind */
package sfr_pkg;

    // kind of the current apb cycle, as seen by the register bank
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'b00, // no access, or a write blocked by the lock
        ACC_READ  = 2'b01,
        ACC_WRITE = 2'b10
    } sfr_access_e;

    localparam int NREG = 5; // registers behind the decoder

    // bit position of each register in the one-hot select
    localparam int IDX_CTRL   = 0;
    localparam int IDX_RELOAD = 1;
    localparam int IDX_COUNT  = 2;
    localparam int IDX_FLAG   = 3;
    localparam int IDX_ACTION = 4;

    // byte offsets from the block base
    localparam logic [11:0] OFS_CTRL   = 12'h000; // control
    localparam logic [11:0] OFS_RELOAD = 12'h004; // reload value
    localparam logic [11:0] OFS_COUNT  = 12'h008; // live count, read only
    localparam logic [11:0] OFS_FLAG   = 12'h00C; // sticky flags, write 1 to clear
    localparam logic [11:0] OFS_ACTION = 12'h010; // action, write only

    // control register fields
    localparam int CTRL_EN_BIT  = 0; // timer enable
    localparam int CTRL_IRQ_BIT = 1; // interrupt enable

    // flag register fields
    localparam int FLAG_OVF_BIT = 0; // counter wrapped

    // writing this value to the action register restarts the counter
    localparam logic [31:0] ACTION_KEY = 32'h0000_005A;

    // reset values
    localparam logic [31:0] CTRL_IV   = 32'h0000_0000;
    localparam logic [31:0] RELOAD_IV = 32'h0000_FFFF;

    // read masks, undefined bits read as zero
    localparam logic [31:0] CTRL_RMASK = 32'h0000_0003;

endpackage

/* rtl/apb_access.sv */
/* apb phase decode for the sfr block
   access kind per cycle and one-hot register select, lock drops writes */
`timescale 1ns/1ns

module apb_access #(
    parameter int AW   = 12, // apb address width
    parameter int BASE = 0   // byte address of the register block
) (
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [AW-1:0]            paddr,
    input  logic                     sfr_lock,
    output sfr_pkg::sfr_access_e     acc_kind,
    output logic [sfr_pkg::NREG-1:0] reg_sel
);

    // absolute register addresses, truncated to the bus width
    localparam logic [AW-1:0] ADDR_CTRL   = AW'(BASE + sfr_pkg::OFS_CTRL);
    localparam logic [AW-1:0] ADDR_RELOAD = AW'(BASE + sfr_pkg::OFS_RELOAD);
    localparam logic [AW-1:0] ADDR_COUNT  = AW'(BASE + sfr_pkg::OFS_COUNT);
    localparam logic [AW-1:0] ADDR_FLAG   = AW'(BASE + sfr_pkg::OFS_FLAG);
    localparam logic [AW-1:0] ADDR_ACTION = AW'(BASE + sfr_pkg::OFS_ACTION);

    logic access_phase; // psel and penable both high

    assign access_phase = psel & penable;

    // setup phase and idle bus both map to ACC_IDLE
    always_comb begin
        acc_kind = sfr_pkg::ACC_IDLE;
        if (access_phase) begin
            if (!pwrite) begin
                acc_kind = sfr_pkg::ACC_READ;  // reads pass even when locked
            end else if (!sfr_lock) begin
                acc_kind = sfr_pkg::ACC_WRITE;
            end
        end
    end

    // address compare, one bit per register
    always_comb begin
        reg_sel[sfr_pkg::IDX_CTRL]   = (paddr == ADDR_CTRL);
        reg_sel[sfr_pkg::IDX_RELOAD] = (paddr == ADDR_RELOAD);
        reg_sel[sfr_pkg::IDX_COUNT]  = (paddr == ADDR_COUNT);
        reg_sel[sfr_pkg::IDX_FLAG]   = (paddr == ADDR_FLAG);
        reg_sel[sfr_pkg::IDX_ACTION] = (paddr == ADDR_ACTION); // unmapped -> all zero
    end

    // a narrow AW or odd BASE could alias two package offsets onto one address
    always_comb begin
        assert ($onehot0(reg_sel))
            else $error("apb_access: register addresses overlap at 0x%0h", paddr);
    end

endmodule

/* rtl/sfr_bank.sv */
/* register bank of the tick timer
   control, reload, count status, sticky overflow flag and action key
   read path is a masked or-merge of the selected register */
`timescale 1ns/1ns

module sfr_bank #(
    parameter int DW = 32, // apb data width
    parameter int CW = 16  // counter width, not above DW
) (
    input  logic                     pclk,
    input  logic                     reset,
    input  sfr_pkg::sfr_access_e     acc_kind,
    input  logic [sfr_pkg::NREG-1:0] reg_sel,
    input  logic [DW-1:0]            pwdata,
    input  logic [CW-1:0]            count,
    input  logic                     ovf_event,
    output logic [DW-1:0]            prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     ctrl_en,
    output logic                     irq_en,
    output logic [CW-1:0]            reload,
    output logic                     restart,
    output logic                     flag_ovf
);

    logic [DW-1:0]            ctrl_q;    // whole word kept, read mask hides spare bits
    logic [CW-1:0]            reload_q;
    logic                     flag_q;    // sticky overflow
    logic                     restart_q; // one-cycle action pulse
    logic [sfr_pkg::NREG-1:0] wr_sel;    // per-register write strobe
    logic                     flag_clr;  // write 1 to clear
    logic                     key_hit;   // action data matches the key
    logic [DW-1:0]            rd_val  [sfr_pkg::NREG];
    logic [DW-1:0]            rd_mask [sfr_pkg::NREG];

    // zero wait states and no error response
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_sel   = (acc_kind == sfr_pkg::ACC_WRITE) ? reg_sel : '0;
    assign flag_clr = wr_sel[sfr_pkg::IDX_FLAG] & pwdata[sfr_pkg::FLAG_OVF_BIT];
    assign key_hit  = (pwdata == DW'(sfr_pkg::ACTION_KEY));

    always_ff @(posedge pclk) begin
        if (reset) begin
            ctrl_q    <= DW'(sfr_pkg::CTRL_IV);
            reload_q  <= CW'(sfr_pkg::RELOAD_IV);
            flag_q    <= 1'b0;
            restart_q <= 1'b0;
        end else begin
            if (wr_sel[sfr_pkg::IDX_CTRL]) begin
                ctrl_q <= pwdata;
            end
            if (wr_sel[sfr_pkg::IDX_RELOAD]) begin
                reload_q <= pwdata[CW-1:0]; // upper bits dropped
            end
            // a new event in the same cycle as a clear keeps the flag set
            flag_q    <= (flag_q & ~flag_clr) | ovf_event;
            restart_q <= wr_sel[sfr_pkg::IDX_ACTION] & key_hit; // other values ignored
        end
    end

    // fields out to the timer core
    assign ctrl_en  = ctrl_q[sfr_pkg::CTRL_EN_BIT];
    assign irq_en   = ctrl_q[sfr_pkg::CTRL_IRQ_BIT];
    assign reload   = reload_q;
    assign restart  = restart_q;
    assign flag_ovf = flag_q;

    // raw read value of each register
    always_comb begin
        rd_val[sfr_pkg::IDX_CTRL]   = ctrl_q;
        rd_val[sfr_pkg::IDX_RELOAD] = DW'(reload_q);
        rd_val[sfr_pkg::IDX_COUNT]  = DW'(count);       // status, straight from the core
        rd_val[sfr_pkg::IDX_FLAG]   = DW'(flag_q) << sfr_pkg::FLAG_OVF_BIT;
        rd_val[sfr_pkg::IDX_ACTION] = '0;               // write only
    end

    // read masks
    always_comb begin
        rd_mask[sfr_pkg::IDX_CTRL]   = DW'(sfr_pkg::CTRL_RMASK);
        rd_mask[sfr_pkg::IDX_RELOAD] = '1;
        rd_mask[sfr_pkg::IDX_COUNT]  = '1;
        rd_mask[sfr_pkg::IDX_FLAG]   = '1;
        rd_mask[sfr_pkg::IDX_ACTION] = '1;
    end

    // or-merge, only the selected register contributes during a read
    always_comb begin
        prdata = '0;
        for (int i = 0; i < sfr_pkg::NREG; i++) begin
            if (acc_kind == sfr_pkg::ACC_READ && reg_sel[i]) begin
                prdata = prdata | (rd_val[i] & rd_mask[i]);
            end
        end
    end

    // apb always puts a setup cycle between two writes, so the key pulse cannot stretch
    a_restart_pulse : assert property (
        @(posedge pclk) disable iff (reset)
        restart |=> !restart
    ) else $error("sfr_bank: restart held for more than one cycle");

endmodule

/* rtl/tick_timer.sv */
/* reloadable tick counter
   wraps from reload to zero with a one-cycle event, registered interrupt */
`timescale 1ns/1ns

module tick_timer #(
    parameter int CW = 16 // counter width
) (
    input  logic          pclk,
    input  logic          reset,
    input  logic          ctrl_en,
    input  logic          irq_en,
    input  logic [CW-1:0] reload,
    input  logic          restart,
    input  logic          flag_ovf,
    output logic [CW-1:0] count,
    output logic          ovf_event,
    output logic          tick_event,
    output logic          irq
);

    logic [CW-1:0] count_q;
    logic          wrap;  // last cycle of a period
    logic          irq_q;

    // >= also catches a count left above a freshly lowered reload
    // restart takes priority, so no event when both land together
    assign wrap = ctrl_en & ~restart & (count_q >= reload);

    always_ff @(posedge pclk) begin
        if (reset) begin
            count_q <= '0;
        end else if (restart) begin
            count_q <= '0;                  // action key, even while disabled
        end else if (ctrl_en) begin
            if (wrap) begin
                count_q <= '0;              // period is reload+1 cycles
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // interrupt follows the sticky flag one cycle later
    always_ff @(posedge pclk) begin
        if (reset) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= flag_ovf & irq_en;
        end
    end

    assign count      = count_q;
    assign ovf_event  = wrap;   // to the flag register
    assign tick_event = wrap;   // to the pin
    assign irq        = irq_q;

    // once running for a cycle with a steady reload, the count stays in range
    a_count_range : assert property (
        @(posedge pclk) disable iff (reset)
        ctrl_en && $past(ctrl_en) && $stable(reload) |-> count_q <= reload
    ) else $error("tick_timer: count 0x%0h above reload 0x%0h", count_q, reload);

endmodule

/* rtl/timer_sfr_top.sv */
/* apb tick timer top level
   apb decode -> register bank -> timer core */
`timescale 1ns/1ns

module timer_sfr_top #(
    parameter int AW   = 12, // apb address width
    parameter int DW   = 32, // apb data width
    parameter int BASE = 0,  // block base address
    parameter int CW   = 16  // counter width
) (
    input  logic          pclk,
    input  logic          reset,
    // apb slave
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [AW-1:0] paddr,
    input  logic [DW-1:0] pwdata,
    output logic [DW-1:0] prdata,
    output logic          pready,
    output logic          pslverr,
    input  logic          sfr_lock,   // blocks every write
    output logic          tick_event, // one cycle per period
    output logic          irq
);

    sfr_pkg::sfr_access_e     acc_kind;
    logic [sfr_pkg::NREG-1:0] reg_sel;
    logic                     ctrl_en;
    logic                     irq_en;
    logic [CW-1:0]            reload;
    logic                     restart;
    logic                     flag_ovf;
    logic [CW-1:0]            count;
    logic                     ovf_event;

    apb_access #(.AW(AW), .BASE(BASE)) u_access (
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .sfr_lock (sfr_lock),
        .acc_kind (acc_kind),
        .reg_sel  (reg_sel)
    );

    sfr_bank #(.DW(DW), .CW(CW)) u_bank (
        .pclk      (pclk),
        .reset     (reset),
        .acc_kind  (acc_kind),
        .reg_sel   (reg_sel),
        .pwdata    (pwdata),
        .count     (count),
        .ovf_event (ovf_event),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ctrl_en   (ctrl_en),
        .irq_en    (irq_en),
        .reload    (reload),
        .restart   (restart),
        .flag_ovf  (flag_ovf)
    );

    tick_timer #(.CW(CW)) u_timer (
        .pclk       (pclk),
        .reset      (reset),
        .ctrl_en    (ctrl_en),
        .irq_en     (irq_en),
        .reload     (reload),
        .restart    (restart),
        .flag_ovf   (flag_ovf),
        .count      (count),
        .ovf_event  (ovf_event),
        .tick_event (tick_event),
        .irq        (irq)
    );

endmodule

/* sim/tb_clock.sv */
/* testbench clock and reset source
   40 ns clock, synchronous reset held for the first cycles */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0; // released on a rising edge, like any other input
    end

endmodule

/* sim/timer_sfr_tb.sv */
/* table-driven testbench for the apb tick timer
   apb read and write tasks, typed compares, lfsr data and a watchdog */
`timescale 1ns/1ns

module timer_sfr_tb;

    localparam int AW     = 12;
    localparam int DW     = 32;
    localparam int BASE   = 0;
    localparam int CW     = 16;
    localparam int CLK_NS = 40;
    localparam int RUN_A  = 40; // idle cycles between enable and disable, first run
    localparam int RUN_B  = 10; // same for the run before the lock test

    localparam logic [AW-1:0] A_CTRL   = AW'(BASE + sfr_pkg::OFS_CTRL);
    localparam logic [AW-1:0] A_RELOAD = AW'(BASE + sfr_pkg::OFS_RELOAD);
    localparam logic [AW-1:0] A_COUNT  = AW'(BASE + sfr_pkg::OFS_COUNT);
    localparam logic [AW-1:0] A_FLAG   = AW'(BASE + sfr_pkg::OFS_FLAG);
    localparam logic [AW-1:0] A_ACTION = AW'(BASE + sfr_pkg::OFS_ACTION);
    localparam logic [AW-1:0] A_HOLE   = AW'(BASE + 12'h014); // just past the map
    localparam logic [AW-1:0] A_FAR    = AW'(BASE + 12'h3FC);

    typedef enum logic [2:0] {
        OP_WRITE, // apb write of data to addr
        OP_READ,  // apb read of addr, compare with exp
        OP_WAIT,  // idle for data cycles
        OP_LOCK,  // drive sfr_lock with data bit 0
        OP_IRQ,   // irq level one edge later vs exp bit 0
        OP_TICK   // look for tick_event within data cycles, seen vs exp bit 0
    } op_e;

    logic          pclk;
    logic          reset;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [AW-1:0] paddr;
    logic [DW-1:0] pwdata;
    logic [DW-1:0] prdata;
    logic          pready;
    logic          pslverr;
    logic          sfr_lock;
    logic          tick_event;
    logic          irq;

    // stimulus table as parallel queues, one entry per row
    string         row_name [$];
    op_e           row_op   [$];
    logic [AW-1:0] row_addr [$];
    logic [DW-1:0] row_data [$];
    logic [DW-1:0] row_exp  [$];

    logic [15:0] lfsr = 16'd20267;
    bit          table_ready = 1'b0;

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) u_clock (
        .clk   (pclk),
        .reset (reset)
    );

    timer_sfr_top #(.AW(AW), .DW(DW), .BASE(BASE), .CW(CW)) dut (
        .pclk       (pclk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .sfr_lock   (sfr_lock),
        .tick_event (tick_event),
        .irq        (irq)
    );

    // galois lfsr with taps 16,14,13,11 stepped once per bit handed out
    function automatic logic [DW-1:0] rand_bits(input int nbits);
        logic [DW-1:0] val;
        logic          lsb;
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 16'hB400;
            end
            val = {val[DW-2:0], lsb};
        end
        return val;
    endfunction

    task automatic add_row(input string name, input op_e op, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data, input logic [DW-1:0] exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(exp);
    endtask

    task automatic check_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] expected 0x%08h, actual 0x%08h", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // setup cycle, access cycle, then bus back to idle; data lands on the third edge
    task automatic apb_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             output logic rdy, output logic err);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        rdy = pready;  // response seen mid access phase
        err = pslverr;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [AW-1:0] addr, output logic [DW-1:0] data,
                            output logic rdy, output logic err);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        data = prdata; // sampled mid access phase
        rdy  = pready;
        err  = pslverr;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_tick(input int max_cycles, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < max_cycles) begin
            @(negedge pclk);
            seen = tick_event;
            n++;
        end
    endtask

    task automatic build_table();
        logic [DW-1:0] rnd_ctrl;
        logic [DW-1:0] rnd_reload;
        rnd_ctrl   = rand_bits(32);
        rnd_reload = rand_bits(16);
        // values after reset
        add_row("reset_ctrl",   OP_READ, A_CTRL,   0, 32'h0);
        add_row("reset_reload", OP_READ, A_RELOAD, 0, 32'hFFFF);
        add_row("reset_count",  OP_READ, A_COUNT,  0, 32'h0);
        add_row("reset_flag",   OP_READ, A_FLAG,   0, 32'h0);
        add_row("unmapped_lo",  OP_READ, A_HOLE,   0, 32'h0);
        add_row("unmapped_hi",  OP_READ, A_FAR,    0, 32'h0);
        add_row("reset_irq",    OP_IRQ,  '0,       0, 32'h0);
        add_row("reset_tick",   OP_TICK, '0,       20, 32'h0); // no tick while disabled
        // ctrl keeps only its two defined bits on random readback
        add_row("ctrl_wr",     OP_WRITE, A_CTRL,   rnd_ctrl,   0);
        add_row("ctrl_rd",     OP_READ,  A_CTRL,   0,          rnd_ctrl & 32'h3);
        add_row("reload_wr",   OP_WRITE, A_RELOAD, rnd_reload, 0);
        add_row("reload_rd",   OP_READ,  A_RELOAD, 0,          rnd_reload);
        // random ctrl may have started the timer
        add_row("stop",        OP_WRITE, A_CTRL,   32'h0,  0);
        add_row("flag_clr",    OP_WRITE, A_FLAG,   32'h1,  0);
        add_row("restart",     OP_WRITE, A_ACTION, 32'h5A, 0);
        add_row("clean_count", OP_READ,  A_COUNT,  0,      32'h0);
        add_row("clean_flag",  OP_READ,  A_FLAG,   0,      32'h0);
        // count steps on every wait edge plus the three edges of the disabling write
        add_row("run_reload",  OP_WRITE, A_RELOAD, 32'd100, 0);
        add_row("run_on",      OP_WRITE, A_CTRL,   32'h1,   0);
        add_row("run_wait",    OP_WAIT,  '0,       RUN_A,   0);
        add_row("run_off",     OP_WRITE, A_CTRL,   32'h0,   0);
        add_row("run_count",   OP_READ,  A_COUNT,  0,       RUN_A + 3);
        add_row("badkey_wr",   OP_WRITE, A_ACTION, 32'hA5,  0);
        add_row("badkey_cnt",  OP_READ,  A_COUNT,  0,       RUN_A + 3);
        add_row("key_wr",      OP_WRITE, A_ACTION, 32'h5A,  0);
        add_row("key_cnt",     OP_READ,  A_COUNT,  0,       32'h0);
        // count left nonzero before the lock so a blocked restart would show
        add_row("pre_on",      OP_WRITE, A_CTRL,   32'h1,   0);
        add_row("pre_wait",    OP_WAIT,  '0,       RUN_B,   0);
        add_row("pre_off",     OP_WRITE, A_CTRL,   32'h0,   0);
        add_row("pre_count",   OP_READ,  A_COUNT,  0,       RUN_B + 3);
        add_row("lock_on",     OP_LOCK,  '0,       32'h1,   0);
        add_row("lock_ctrl",   OP_WRITE, A_CTRL,   32'h3,   0);
        add_row("lock_key",    OP_WRITE, A_ACTION, 32'h5A,  0);
        add_row("lock_reload", OP_WRITE, A_RELOAD, 32'h1234, 0);
        add_row("lock_rd_ctl", OP_READ,  A_CTRL,   0,       32'h0);
        add_row("lock_rd_cnt", OP_READ,  A_COUNT,  0,       RUN_B + 3);
        add_row("lock_rd_rld", OP_READ,  A_RELOAD, 0,       32'd100);
        add_row("lock_off",    OP_LOCK,  '0,       32'h0,   0);
        // overflow flag and interrupt
        add_row("ovf_restart", OP_WRITE, A_ACTION, 32'h5A,  0);
        add_row("ovf_reload",  OP_WRITE, A_RELOAD, 32'd5,   0);
        add_row("ovf_on",      OP_WRITE, A_CTRL,   32'h3,   0);
        add_row("ovf_tick",    OP_TICK,  '0,       20,      32'h1); // period of 6
        add_row("ovf_wait",    OP_WAIT,  '0,       10,      0);
        add_row("ovf_off",     OP_WRITE, A_CTRL,   32'h2,   0); // irq enable stays on
        add_row("ovf_flag",    OP_READ,  A_FLAG,   0,       32'h1);
        add_row("ovf_irq",     OP_IRQ,   '0,       0,       32'h1);
        add_row("w0_flag",     OP_WRITE, A_FLAG,   32'h0,   0);
        add_row("w0_flag_rd",  OP_READ,  A_FLAG,   0,       32'h1);
        add_row("w0_irq",      OP_IRQ,   '0,       0,       32'h1);
        add_row("w1c_flag",    OP_WRITE, A_FLAG,   32'h1,   0);
        add_row("w1c_irq",     OP_IRQ,   '0,       0,       32'h0); // one edge after clear
        add_row("w1c_flag_rd", OP_READ,  A_FLAG,   0,       32'h0);
        add_row("off_tick",    OP_TICK,  '0,       20,      32'h0);
    endtask

    // watchdog allows 20 cycles per table row
    initial begin
        longint watch_ns;
        wait (table_ready);
        watch_ns = longint'(row_name.size()) * 20 * CLK_NS;
        #(watch_ns);
        $display("timeout: stimulus table not finished after %0d ns", watch_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [DW-1:0] rd;
        logic          seen;
        logic          rdy;
        logic          err;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        sfr_lock = 1'b0;
        build_table();
        table_ready = 1'b1;
        @(negedge reset);
        for (int i = 0; i < row_name.size(); i++) begin
            case (row_op[i])
                OP_WRITE: begin
                    apb_write(row_addr[i], row_data[i], rdy, err);
                    check_bit({row_name[i], " pready"}, 1'b1, rdy);
                    check_bit({row_name[i], " pslverr"}, 1'b0, err);
                end
                OP_READ: begin
                    apb_read(row_addr[i], rd, rdy, err);
                    check_bit({row_name[i], " pready"}, 1'b1, rdy);
                    check_bit({row_name[i], " pslverr"}, 1'b0, err);
                    check_data(row_name[i], row_exp[i], rd);
                end
                OP_WAIT: repeat (row_data[i]) @(posedge pclk);
                OP_LOCK: begin
                    @(posedge pclk);
                    sfr_lock <= row_data[i][0];
                end
                OP_IRQ: begin
                    @(posedge pclk);
                    @(negedge pclk);
                    check_bit(row_name[i], row_exp[i][0], irq);
                end
                OP_TICK: begin
                    wait_tick(row_data[i], seen);
                    check_bit(row_name[i], row_exp[i][0], seen);
                end
                default: ;
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* list.f */
rtl/sfr_pkg.sv
rtl/apb_access.sv
rtl/sfr_bank.sv
rtl/tick_timer.sv
rtl/timer_sfr_top.sv
sim/tb_clock.sv
sim/timer_sfr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the apb tick timer testbench with verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module timer_sfr_tb \
    -f list.f \
    -Mdir obj_dir \
    -o timer_sfr_sim

# tee keeps the pipeline status at zero, the log search decides the result
./obj_dir/timer_sfr_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
